// File: flist.f
+incdir+dv
verilog/cpu_cfg_pkg.sv
verilog/uop_pkg.sv
verilog/issue_lane_if.sv
verilog/gpr_file.sv
verilog/operand_select.sv
verilog/regread_pipe_reg.sv
verilog/regread_top.sv
dv/regread_tb.sv

// File: dv/regread_ref_model.svh
// Reference model for register read. Shadow registers hold X until written, so the first cycles fill them.
`ifndef REGREAD_REF_MODEL_SVH
`define REGREAD_REF_MODEL_SVH

logic [cpu_cfg_pkg::xlen-1:0] shadow [cpu_cfg_pkg::reg_count];
logic [31:0]                  lcg_state;

// ----------------------------------------
// random source
// ----------------------------------------

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state ^ (lcg_state >> 16);                       // mix weak low bits.
endfunction

// ----------------------------------------
// register file view
// ----------------------------------------

function automatic logic [31:0] read_shadow(input logic [4:0] addr,
                                            input logic we0, input logic [4:0] wa0,
                                            input logic [31:0] wd0,
                                            input logic we1, input logic [4:0] wa1,
                                            input logic [31:0] wd1);
    if (addr == 5'd0) return 32'd0;
    if (we1 && wa1 == addr) return wd1;                         // port 1 is newest.
    if (we0 && wa0 == addr) return wd0;
    return shadow[addr];
endfunction

task automatic store_shadow(input logic we0, input logic [4:0] wa0, input logic [31:0] wd0,
                            input logic we1, input logic [4:0] wa1, input logic [31:0] wd1);
    if (we0 && wa0 != 5'd0) shadow[wa0] = wd0;
    if (we1 && wa1 != 5'd0) shadow[wa1] = wd1;
endtask

// ----------------------------------------
// operand choice
// ----------------------------------------

function automatic logic [31:0] expect_a(input logic [15:0] uop, input logic [31:0] rf,
                                         input logic [31:0] pc);
    logic [1:0] src;
    src = uop[uop_pkg::uop_src1_lsb +: 2];
    if (uop[uop_pkg::uop_type_lsb +: uop_pkg::uop_type_w] != uop_pkg::itype_alu) return rf;
    if (src == uop_pkg::src1_rf) return rf;
    if (src == uop_pkg::src1_pc) return pc;
    return 32'd0;                                               // zero and cntid.
endfunction

function automatic logic [31:0] expect_b(input logic [15:0] uop, input logic [31:0] rf,
                                         input logic [31:0] imm, input logic [63:0] cnt);
    logic [1:0] src;
    src = uop[uop_pkg::uop_src2_lsb +: 2];
    if (uop[uop_pkg::uop_type_lsb +: uop_pkg::uop_type_w] != uop_pkg::itype_alu) return rf;
    if (src == uop_pkg::src2_rf) return rf;
    if (src == uop_pkg::src2_imm) return imm;
    if (src == uop_pkg::src2_cntl) return cnt[31:0];
    return cnt[63:32];
endfunction

`endif

// File: dv/regread_tb.sv
// Random testbench for register read. The first 16 cycles fill every register before any read.
module regread_tb;

`include "regread_ref_model.svh"

    localparam int lane_w = 1 + uop_pkg::uop_w + 3 * cpu_cfg_pkg::reg_addr_w
                          + 3 * cpu_cfg_pkg::xlen + cpu_cfg_pkg::exp_w;
    localparam int n_cycles = 600;

    logic clk, rst_n, stall, flush;
    logic write_en_0, write_en_1;
    logic [4:0]  write_addr_0, write_addr_1;
    logic [31:0] write_data_0, write_data_1;
    logic [63:0] stable_counter;
    logic        eu0_en, eu1_en, eu0_en_out, eu1_en_out;
    logic [15:0] eu0_uop, eu1_uop, eu0_uop_out, eu1_uop_out;
    logic [4:0]  eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    logic [4:0]  eu0_rd_out, eu0_rj_out, eu0_rk_out, eu1_rd_out, eu1_rj_out, eu1_rk_out;
    logic [31:0] eu0_pc, eu0_pc_next, eu0_imm, eu1_pc, eu1_pc_next, eu1_imm;
    logic [31:0] eu0_pc_out, eu0_pc_next_out, eu0_imm_out;
    logic [31:0] eu1_pc_out, eu1_pc_next_out, eu1_imm_out;
    logic [31:0] eu0_operand_a, eu0_operand_b, eu1_operand_a, eu1_operand_b;
    logic [6:0]  eu0_exp, eu1_exp, eu0_exp_out, eu1_exp_out;

    logic [lane_w-1:0] exp_fields [2];
    logic [31:0]       exp_opa [2];
    logic [31:0]       exp_opb [2];
    int                errors;
    int                checks;

    regread_top regread_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog.
    initial begin
        for (int i = 0; i < n_cycles + 100; i++) @(posedge clk);
        $display("timeout: the test loop did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    task automatic compare_value(input string what, input logic [lane_w-1:0] got,
                                 input logic [lane_w-1:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_outputs();
        compare_value("eu0 fields", {eu0_en_out, eu0_uop_out, eu0_rd_out, eu0_rj_out,
            eu0_rk_out, eu0_pc_out, eu0_pc_next_out, eu0_exp_out, eu0_imm_out}, exp_fields[0]);
        compare_value("eu1 fields", {eu1_en_out, eu1_uop_out, eu1_rd_out, eu1_rj_out,
            eu1_rk_out, eu1_pc_out, eu1_pc_next_out, eu1_exp_out, eu1_imm_out}, exp_fields[1]);
        compare_value("eu0 operand a", eu0_operand_a, exp_opa[0]);
        compare_value("eu0 operand b", eu0_operand_b, exp_opb[0]);
        compare_value("eu1 operand a", eu1_operand_a, exp_opa[1]);
        compare_value("eu1 operand b", eu1_operand_b, exp_opb[1]);
    endtask

    task automatic make_lane(input bit fill, output logic en, output logic [15:0] uop,
                             output logic [4:0] rd, output logic [4:0] rj,
                             output logic [4:0] rk, output logic [31:0] pc,
                             output logic [31:0] pc_next, output logic [6:0] exp,
                             output logic [31:0] imm);
        logic [31:0] r;
        r = next_rand();
        en = r[31];
        uop = r[15:0];
        if (r[16]) uop[uop_pkg::uop_type_lsb +: uop_pkg::uop_type_w] = uop_pkg::itype_alu;
        rd = r[21:17];
        r = next_rand();
        rj = r[20] ? {3'd0, r[1:0]} : r[4:0];               // small indices hit r0 often.
        rk = r[21] ? {3'd0, r[6:5]} : r[11:7];
        if (fill) begin
            rj = 5'd0;
            rk = 5'd0;
        end
        pc = next_rand();
        pc_next = next_rand();
        exp = r[28:22];
        imm = next_rand();
    endtask

    task automatic drive_cycle(input int cyc);
        logic [31:0] r;
        make_lane(cyc < 16, eu0_en, eu0_uop, eu0_rd, eu0_rj, eu0_rk, eu0_pc, eu0_pc_next,
                  eu0_exp, eu0_imm);
        make_lane(cyc < 16, eu1_en, eu1_uop, eu1_rd, eu1_rj, eu1_rk, eu1_pc, eu1_pc_next,
                  eu1_exp, eu1_imm);
        r = next_rand();
        stable_counter = {next_rand(), next_rand()};
        write_data_0 = next_rand();
        write_data_1 = next_rand();
        write_en_0 = r[0] | r[1];
        write_en_1 = r[2] | r[3];
        write_addr_0 = r[4] ? eu0_rj : r[9:5];              // aim at a read for bypass.
        write_addr_1 = r[10] ? write_addr_0 : (r[11] ? eu1_rk : r[16:12]);
        stall = (r[19:17] == 3'd0);
        flush = (r[23:20] == 4'd0);
        if (cyc < 16) begin
            write_en_0 = 1'b1;
            write_en_1 = 1'b1;
            write_addr_0 = 5'(2 * cyc);
            write_addr_1 = 5'(2 * cyc + 1);
            stall = 1'b0;
            flush = 1'b0;
        end
    endtask

    // expected outputs after the coming edge, then the writes of that edge.
    task automatic predict();
        logic [31:0] rf [4];
        rf[0] = read_shadow(eu0_rj, write_en_0, write_addr_0, write_data_0,
                            write_en_1, write_addr_1, write_data_1);
        rf[1] = read_shadow(eu0_rk, write_en_0, write_addr_0, write_data_0,
                            write_en_1, write_addr_1, write_data_1);
        rf[2] = read_shadow(eu1_rj, write_en_0, write_addr_0, write_data_0,
                            write_en_1, write_addr_1, write_data_1);
        rf[3] = read_shadow(eu1_rk, write_en_0, write_addr_0, write_data_0,
                            write_en_1, write_addr_1, write_data_1);
        if (flush) begin
            exp_fields = '{default: '0};
            exp_opa = '{default: '0};
            exp_opb = '{default: '0};
        end else if (!stall) begin
            exp_fields[0] = {eu0_en, eu0_uop, eu0_rd, eu0_rj, eu0_rk, eu0_pc, eu0_pc_next,
                             eu0_exp, eu0_imm};
            exp_fields[1] = {eu1_en, eu1_uop, eu1_rd, eu1_rj, eu1_rk, eu1_pc, eu1_pc_next,
                             eu1_exp, eu1_imm};
            exp_opa[0] = expect_a(eu0_uop, rf[0], eu0_pc);
            exp_opb[0] = expect_b(eu0_uop, rf[1], eu0_imm, stable_counter);
            exp_opa[1] = expect_a(eu1_uop, rf[2], eu1_pc);
            exp_opb[1] = expect_b(eu1_uop, rf[3], eu1_imm, stable_counter);
        end
        store_shadow(write_en_0, write_addr_0, write_data_0,
                     write_en_1, write_addr_1, write_data_1);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        int guard;
        {rst_n, stall, flush, write_en_0, write_en_1, write_addr_0, write_addr_1} = '0;
        {write_data_0, write_data_1} = '0;
        stable_counter = '1;
        // busy lanes during reset, so only the reset can clear the outputs.
        {eu0_en, eu0_uop, eu0_rd, eu0_rj, eu0_rk, eu0_pc, eu0_pc_next, eu0_exp, eu0_imm} = '1;
        {eu1_en, eu1_uop, eu1_rd, eu1_rj, eu1_rk, eu1_pc, eu1_pc_next, eu1_exp, eu1_imm} = '1;
        lcg_state = 32'h9875;
        errors = 0;
        checks = 0;
        exp_fields = '{default: '0};
        exp_opa = '{default: '0};
        exp_opb = '{default: '0};
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        guard = 0;
        while ((eu0_en_out !== 1'b0 || eu1_en_out !== 1'b0) && guard < 10) begin
            @(posedge clk);
            guard++;
        end
        if (guard == 10) begin
            errors++;
            $display("lane enables did not clear after reset");
        end
        check_outputs();                                        // all zero after reset.
        for (int cyc = 0; cyc < n_cycles; cyc++) begin
            drive_cycle(cyc);
            predict();
            @(posedge clk);
            #1 check_outputs();
            #1;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/regread_top.sv
// Register-read stage for two lanes. Writes land even while stalled and register contents are not reset.
module regread_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall,
    input  logic                               flush,
    // writeback ports
    input  logic                               write_en_0,
    input  logic                               write_en_1,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] write_addr_0,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] write_addr_1,
    input  logic [cpu_cfg_pkg::xlen-1:0]       write_data_0,
    input  logic [cpu_cfg_pkg::xlen-1:0]       write_data_1,
    input  logic [cpu_cfg_pkg::cnt_w-1:0]      stable_counter,
    // issue, lane 0
    input  logic                               eu0_en,
    input  logic [uop_pkg::uop_w-1:0]          eu0_uop,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] eu0_rd,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] eu0_rj,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] eu0_rk,
    input  logic [cpu_cfg_pkg::xlen-1:0]       eu0_pc,
    input  logic [cpu_cfg_pkg::xlen-1:0]       eu0_pc_next,
    input  logic [cpu_cfg_pkg::exp_w-1:0]      eu0_exp,
    input  logic [cpu_cfg_pkg::xlen-1:0]       eu0_imm,
    // issue, lane 1
    input  logic                               eu1_en,
    input  logic [uop_pkg::uop_w-1:0]          eu1_uop,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] eu1_rd,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] eu1_rj,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] eu1_rk,
    input  logic [cpu_cfg_pkg::xlen-1:0]       eu1_pc,
    input  logic [cpu_cfg_pkg::xlen-1:0]       eu1_pc_next,
    input  logic [cpu_cfg_pkg::exp_w-1:0]      eu1_exp,
    input  logic [cpu_cfg_pkg::xlen-1:0]       eu1_imm,
    // to execute, lane 0
    output logic                               eu0_en_out,
    output logic [uop_pkg::uop_w-1:0]          eu0_uop_out,
    output logic [cpu_cfg_pkg::reg_addr_w-1:0] eu0_rd_out,
    output logic [cpu_cfg_pkg::reg_addr_w-1:0] eu0_rj_out,
    output logic [cpu_cfg_pkg::reg_addr_w-1:0] eu0_rk_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu0_pc_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu0_pc_next_out,
    output logic [cpu_cfg_pkg::exp_w-1:0]      eu0_exp_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu0_imm_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu0_operand_a,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu0_operand_b,
    // to execute, lane 1
    output logic                               eu1_en_out,
    output logic [uop_pkg::uop_w-1:0]          eu1_uop_out,
    output logic [cpu_cfg_pkg::reg_addr_w-1:0] eu1_rd_out,
    output logic [cpu_cfg_pkg::reg_addr_w-1:0] eu1_rj_out,
    output logic [cpu_cfg_pkg::reg_addr_w-1:0] eu1_rk_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu1_pc_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu1_pc_next_out,
    output logic [cpu_cfg_pkg::exp_w-1:0]      eu1_exp_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu1_imm_out,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu1_operand_a,
    output logic [cpu_cfg_pkg::xlen-1:0]       eu1_operand_b
);

    logic [cpu_cfg_pkg::reg_addr_w-1:0] rf_raddr [4];
    logic [cpu_cfg_pkg::xlen-1:0]       rf_rdata [4];
    logic [cpu_cfg_pkg::xlen-1:0]       opa [2];
    logic [cpu_cfg_pkg::xlen-1:0]       opb [2];

    issue_lane_if   lane0 ();
    issue_lane_if   lane1 ();
    regread_lane_if out0 ();
    regread_lane_if out1 ();

    // ----------------------------------------
    // issue side
    // ----------------------------------------

    assign lane0.en      = eu0_en;
    assign lane0.uop     = eu0_uop;
    assign lane0.rd      = eu0_rd;
    assign lane0.rj      = eu0_rj;
    assign lane0.rk      = eu0_rk;
    assign lane0.pc      = eu0_pc;
    assign lane0.pc_next = eu0_pc_next;
    assign lane0.exp     = eu0_exp;
    assign lane0.imm     = eu0_imm;

    assign lane1.en      = eu1_en;
    assign lane1.uop     = eu1_uop;
    assign lane1.rd      = eu1_rd;
    assign lane1.rj      = eu1_rj;
    assign lane1.rk      = eu1_rk;
    assign lane1.pc      = eu1_pc;
    assign lane1.pc_next = eu1_pc_next;
    assign lane1.exp     = eu1_exp;
    assign lane1.imm     = eu1_imm;

    // read ports 0,1 serve lane 0 and 2,3 serve lane 1.
    assign rf_raddr[0] = lane0.rj;
    assign rf_raddr[1] = lane0.rk;
    assign rf_raddr[2] = lane1.rj;
    assign rf_raddr[3] = lane1.rk;

    gpr_file gpr_file_i (
        .clk          (clk),
        .write_en_0   (write_en_0),
        .write_en_1   (write_en_1),
        .write_addr_0 (write_addr_0),
        .write_addr_1 (write_addr_1),
        .write_data_0 (write_data_0),
        .write_data_1 (write_data_1),
        .read_addr    (rf_raddr),
        .read_data    (rf_rdata)
    );

    // ----------------------------------------
    // per-lane select and stage register
    // ----------------------------------------

    operand_select sel0_i (
        .lane           (lane0),
        .rf_a           (rf_rdata[0]),
        .rf_b           (rf_rdata[1]),
        .stable_counter (stable_counter),
        .operand_a      (opa[0]),
        .operand_b      (opb[0])
    );

    operand_select sel1_i (
        .lane           (lane1),
        .rf_a           (rf_rdata[2]),
        .rf_b           (rf_rdata[3]),
        .stable_counter (stable_counter),
        .operand_a      (opa[1]),
        .operand_b      (opb[1])
    );

    regread_pipe_reg stage0_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .lane      (lane0),
        .operand_a (opa[0]),
        .operand_b (opb[0]),
        .q         (out0)
    );

    regread_pipe_reg stage1_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .lane      (lane1),
        .operand_a (opa[1]),
        .operand_b (opb[1]),
        .q         (out1)
    );

    // ----------------------------------------
    // execute side
    // ----------------------------------------

    assign eu0_en_out      = out0.en;
    assign eu0_uop_out     = out0.uop;
    assign eu0_rd_out      = out0.rd;
    assign eu0_rj_out      = out0.rj;
    assign eu0_rk_out      = out0.rk;
    assign eu0_pc_out      = out0.pc;
    assign eu0_pc_next_out = out0.pc_next;
    assign eu0_exp_out     = out0.exp;
    assign eu0_imm_out     = out0.imm;
    assign eu0_operand_a   = out0.operand_a;
    assign eu0_operand_b   = out0.operand_b;

    assign eu1_en_out      = out1.en;
    assign eu1_uop_out     = out1.uop;
    assign eu1_rd_out      = out1.rd;
    assign eu1_rj_out      = out1.rj;
    assign eu1_rk_out      = out1.rk;
    assign eu1_pc_out      = out1.pc;
    assign eu1_pc_next_out = out1.pc_next;
    assign eu1_exp_out     = out1.exp;
    assign eu1_imm_out     = out1.imm;
    assign eu1_operand_a   = out1.operand_a;
    assign eu1_operand_b   = out1.operand_b;

endmodule

// File: verilog/regread_pipe_reg.sv
// One-cycle stage register. Flush beats stall and every field clears on reset, en included.
module regread_pipe_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,
    input  logic                         flush,
    issue_lane_if.stage                  lane,
    input  logic [cpu_cfg_pkg::xlen-1:0] operand_a,
    input  logic [cpu_cfg_pkg::xlen-1:0] operand_b,
    regread_lane_if.out                  q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q.en        <= 1'b0;
            q.uop       <= '0;
            q.rd        <= '0;
            q.rj        <= '0;
            q.rk        <= '0;
            q.pc        <= '0;
            q.pc_next   <= '0;
            q.exp       <= '0;
            q.imm       <= '0;
            q.operand_a <= '0;
            q.operand_b <= '0;
        end else if (flush) begin
            // squash the whole slot, not just en.
            q.en        <= 1'b0;
            q.uop       <= '0;
            q.rd        <= '0;
            q.rj        <= '0;
            q.rk        <= '0;
            q.pc        <= '0;
            q.pc_next   <= '0;
            q.exp       <= '0;
            q.imm       <= '0;
            q.operand_a <= '0;
            q.operand_b <= '0;
        end else if (!stall) begin
            q.en        <= lane.en;
            q.uop       <= lane.uop;
            q.rd        <= lane.rd;
            q.rj        <= lane.rj;
            q.rk        <= lane.rk;
            q.pc        <= lane.pc;
            q.pc_next   <= lane.pc_next;
            q.exp       <= lane.exp;
            q.imm       <= lane.imm;
            q.operand_a <= operand_a;                           // already bypassed.
            q.operand_b <= operand_b;
        end
    end

endmodule

// File: verilog/operand_select.sv
// Combinational. Source fields apply to ALU uops only and cntid always yields zero.
module operand_select (
    issue_lane_if.sel                     lane,
    input  logic [cpu_cfg_pkg::xlen-1:0]  rf_a,
    input  logic [cpu_cfg_pkg::xlen-1:0]  rf_b,
    input  logic [cpu_cfg_pkg::cnt_w-1:0] stable_counter,
    output logic [cpu_cfg_pkg::xlen-1:0]  operand_a,
    output logic [cpu_cfg_pkg::xlen-1:0]  operand_b
);

    logic [uop_pkg::uop_type_w-1:0] uop_type;
    logic [uop_pkg::uop_src_w-1:0]  src1;
    logic [uop_pkg::uop_src_w-1:0]  src2;
    logic                           is_alu;

    assign uop_type = lane.uop[uop_pkg::uop_type_lsb +: uop_pkg::uop_type_w];
    assign src1 = lane.uop[uop_pkg::uop_src1_lsb +: uop_pkg::uop_src_w];
    assign src2 = lane.uop[uop_pkg::uop_src2_lsb +: uop_pkg::uop_src_w];
    assign is_alu = (uop_type == uop_pkg::itype_alu);

    // ----------------------------------------
    // operand a
    // ----------------------------------------

    always_comb begin
        operand_a = rf_a;                                       // non-ALU default.
        if (is_alu) begin
            case (src1)
                uop_pkg::src1_rf:    operand_a = rf_a;
                uop_pkg::src1_pc:    operand_a = lane.pc;
                uop_pkg::src1_zero:  operand_a = '0;
                uop_pkg::src1_cntid: operand_a = '0;            // single core.
                default:             operand_a = rf_a;
            endcase
        end
    end

    // ----------------------------------------
    // operand b
    // ----------------------------------------

    always_comb begin
        operand_b = rf_b;
        if (is_alu) begin
            case (src2)
                uop_pkg::src2_rf:   operand_b = rf_b;
                uop_pkg::src2_imm:  operand_b = lane.imm;
                uop_pkg::src2_cntl: operand_b = stable_counter[cpu_cfg_pkg::xlen-1:0];
                uop_pkg::src2_cnth:
                    operand_b = stable_counter[cpu_cfg_pkg::cnt_w-1:cpu_cfg_pkg::xlen];
                default:            operand_b = rf_b;
            endcase
        end
    end

endmodule

// File: verilog/gpr_file.sv
// Storage is not reset. Writes to r0 are dropped and port 1 wins when both ports hit one address.
module gpr_file (
    input  logic                               clk,
    input  logic                               write_en_0,
    input  logic                               write_en_1,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] write_addr_0,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] write_addr_1,
    input  logic [cpu_cfg_pkg::xlen-1:0]       write_data_0,
    input  logic [cpu_cfg_pkg::xlen-1:0]       write_data_1,
    input  logic [cpu_cfg_pkg::reg_addr_w-1:0] read_addr [4],
    output logic [cpu_cfg_pkg::xlen-1:0]       read_data [4]
);

    logic [cpu_cfg_pkg::xlen-1:0] regs [cpu_cfg_pkg::reg_count];

    logic wr_hit_0;
    logic wr_hit_1;

    // a write lands only if enabled and not aimed at r0.
    assign wr_hit_0 = write_en_0 && (write_addr_0 != '0);
    assign wr_hit_1 = write_en_1 && (write_addr_1 != '0);

    // ----------------------------------------
    // write ports
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (wr_hit_0) begin
            regs[write_addr_0] <= write_data_0;
        end
        // later assignment takes effect on a shared address.
        if (wr_hit_1) begin
            regs[write_addr_1] <= write_data_1;
        end
    end

    // ----------------------------------------
    // read ports with same-cycle bypass
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (read_addr[i] == '0) begin
                read_data[i] = '0;                              // hardwired zero.
            end else if (wr_hit_1 && (write_addr_1 == read_addr[i])) begin
                read_data[i] = write_data_1;                    // newest value first.
            end else if (wr_hit_0 && (write_addr_0 == read_addr[i])) begin
                read_data[i] = write_data_0;
            end else begin
                read_data[i] = regs[read_addr[i]];
            end
        end
    end

endmodule

// File: verilog/issue_lane_if.sv
// Lane bundles for register read. Both interfaces carry plain bits and no handshake beyond en.
interface issue_lane_if;

    logic                               en;
    logic [uop_pkg::uop_w-1:0]          uop;
    logic [cpu_cfg_pkg::reg_addr_w-1:0] rd;
    logic [cpu_cfg_pkg::reg_addr_w-1:0] rj;
    logic [cpu_cfg_pkg::reg_addr_w-1:0] rk;
    logic [cpu_cfg_pkg::xlen-1:0]       pc;
    logic [cpu_cfg_pkg::xlen-1:0]       pc_next;
    logic [cpu_cfg_pkg::exp_w-1:0]      exp;
    logic [cpu_cfg_pkg::xlen-1:0]       imm;

    modport src (output en, uop, rd, rj, rk, pc, pc_next, exp, imm);

    modport sel (input uop, rj, rk, pc, imm);

    modport stage (input en, uop, rd, rj, rk, pc, pc_next, exp, imm);

endinterface

// registered lane, as handed to execute
interface regread_lane_if;

    logic                               en;
    logic [uop_pkg::uop_w-1:0]          uop;
    logic [cpu_cfg_pkg::reg_addr_w-1:0] rd;
    logic [cpu_cfg_pkg::reg_addr_w-1:0] rj;
    logic [cpu_cfg_pkg::reg_addr_w-1:0] rk;
    logic [cpu_cfg_pkg::xlen-1:0]       pc;
    logic [cpu_cfg_pkg::xlen-1:0]       pc_next;
    logic [cpu_cfg_pkg::exp_w-1:0]      exp;
    logic [cpu_cfg_pkg::xlen-1:0]       imm;
    logic [cpu_cfg_pkg::xlen-1:0]       operand_a;
    logic [cpu_cfg_pkg::xlen-1:0]       operand_b;

    modport out (output en, uop, rd, rj, rk, pc, pc_next, exp, imm, operand_a, operand_b);

    modport view (input en, uop, rd, rj, rk, pc, pc_next, exp, imm, operand_a, operand_b);

endinterface

// File: verilog/uop_pkg.sv
// Micro-op layout seen by register read. Only the type and the two source fields are decoded here.
package uop_pkg;

    // ----------------------------------------
    // layout
    // ----------------------------------------

    localparam int uop_w = 16;          // whole micro-op.

    // type field, bits [2:0].
    localparam int uop_type_lsb = 0;
    localparam int uop_type_w = 3;

    // operand source selects, 2 bits each.
    localparam int uop_src_w = 2;
    localparam int uop_src1_lsb = 3;    // bits [4:3].
    localparam int uop_src2_lsb = 5;    // bits [6:5].

    // upper bits belong to execute control and pass through untouched

    // ----------------------------------------
    // type codes
    // ----------------------------------------

    // only ALU uops honour the source fields.
    localparam logic [uop_type_w-1:0] itype_alu = 3'd1;

    // ----------------------------------------
    // operand 1 sources
    // ----------------------------------------

    localparam logic [uop_src_w-1:0] src1_rf = 2'd0;     // register rj.
    localparam logic [uop_src_w-1:0] src1_pc = 2'd1;     // uop pc.
    localparam logic [uop_src_w-1:0] src1_zero = 2'd2;
    localparam logic [uop_src_w-1:0] src1_cntid = 2'd3;  // counter id, zero here.

    // ----------------------------------------
    // operand 2 sources
    // ----------------------------------------

    localparam logic [uop_src_w-1:0] src2_rf = 2'd0;     // register rk.
    localparam logic [uop_src_w-1:0] src2_imm = 2'd1;    // decoded immediate.
    localparam logic [uop_src_w-1:0] src2_cntl = 2'd2;   // counter low word.
    localparam logic [uop_src_w-1:0] src2_cnth = 2'd3;   // counter high word.

endpackage

// File: verilog/cpu_cfg_pkg.sv
// Core-wide sizes. The stable counter must be exactly two data words wide for the counter-half operands.
package cpu_cfg_pkg;

    // ----------------------------------------
    // data path
    // ----------------------------------------

    // data word width.
    localparam int xlen = 32;

    // ----------------------------------------
    // register file
    // ----------------------------------------

    // register index width.
    localparam int reg_addr_w = 5;

    // r0 included, always reads zero.
    localparam int reg_count = 32;

    // ----------------------------------------
    // misc
    // ----------------------------------------

    // exception code carried with each uop.
    localparam int exp_w = 7;

    // free-running stable counter, two words.
    localparam int cnt_w = 64;

endpackage
